/* list.f */
+incdir+source
+incdir+tb
source/mp_pkg.sv
source/mp_sync_ram.sv
source/mp_dict_processor.sv
source/mp_max_identifier.sv
source/mp_main_loop.sv
source/mp_alg_fsm.sv
source/mp_engine.sv
tb/tb_mp_engine.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= list.f
TB_TOP    ?= tb_mp_engine
RTL_TOP   ?= mp_engine
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_TEXT ?= All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* tb/mp_ref_model.svh */
`ifndef MP_REF_MODEL_SVH
`define MP_REF_MODEL_SVH

// behavioral matching pursuit over y_model, dict_model, r_model and x_model

function automatic mp_pkg::sample_t atom_correlation(input int atom);
    mp_pkg::acc_t sum;
    sum = '0;
    for (int i = 0; i < `MP_SIGNAL_SIZE; i++) begin
        sum = sum + mp_pkg::acc_t'(r_model[i])
                  * mp_pkg::acc_t'(dict_model[atom * `MP_SIGNAL_SIZE + i]);
    end
    return mp_pkg::sample_t'(sum >>> `MP_FRAC_BITS);
endfunction

function automatic int magnitude(input mp_pkg::sample_t value);
    return (value < 0) ? -int'(value) : int'(value);
endfunction

task automatic predict_solution();
    int              best_atom;
    mp_pkg::sample_t best_value;
    mp_pkg::sample_t product;
    mp_pkg::acc_t    scaled;
    for (int i = 0; i < `MP_SIGNAL_SIZE; i++) begin
        r_model[i] = y_model[i];
    end
    for (int j = 0; j < `MP_DICT_SIZE; j++) begin
        x_model[j] = '0;
    end
    for (int k = 0; k < `MP_SPARSITY; k++) begin
        best_atom  = 0;
        best_value = atom_correlation(0);
        // only a strictly larger magnitude moves the winner
        for (int j = 1; j < `MP_DICT_SIZE; j++) begin
            product = atom_correlation(j);
            if (magnitude(product) > magnitude(best_value)) begin
                best_atom  = j;
                best_value = product;
            end
        end
        x_model[best_atom] = x_model[best_atom] + mp_pkg::coef_t'(best_value);
        for (int i = 0; i < `MP_SIGNAL_SIZE; i++) begin
            scaled = mp_pkg::acc_t'(best_value)
                   * mp_pkg::acc_t'(dict_model[best_atom * `MP_SIGNAL_SIZE + i]);
            r_model[i] = r_model[i] - mp_pkg::sample_t'(scaled >>> `MP_FRAC_BITS);
        end
    end
endtask

`endif

/* tb/tb_mp_engine.sv */
`timescale 1ns/1ns
`include "mp_macros.svh"

module tb_mp_engine;

    // six runs of load, run and readback, each well under 1000 cycles
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int DICT_WORDS = `MP_DICT_SIZE * `MP_SIGNAL_SIZE;

    logic               clock;
    logic               reset_n;
    logic               load_write;
    logic               load_target;
    mp_pkg::dict_addr_t load_addr;
    mp_pkg::sample_t    load_data;
    logic               start;
    logic               done;
    mp_pkg::atom_addr_t x_read_addr;
    mp_pkg::coef_t      x_read_data;

    mp_pkg::sample_t y_model [`MP_SIGNAL_SIZE];
    mp_pkg::sample_t dict_model [DICT_WORDS];
    mp_pkg::sample_t r_model [`MP_SIGNAL_SIZE];
    mp_pkg::coef_t   x_model [`MP_DICT_SIZE];

    int          done_count = 0;
    int          cycle_count = 0;

    `include "mp_ref_model.svh"

    mp_engine dut_i (
        .clock(clock), .reset_n(reset_n),
        .load_write(load_write), .load_target(load_target),
        .load_addr(load_addr), .load_data(load_data),
        .start(start), .done(done),
        .x_read_addr(x_read_addr), .x_read_data(x_read_data)
    );

    always #20 clock = ~clock;

    // one-cycle done pulses are counted mid-cycle
    always @(negedge clock) begin
        if (reset_n && done) begin
            done_count <= done_count + 1;
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the engine did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $fatal(1);
        end
    end

    task automatic check_value(input longint actual, input longint expected,
                               input string what);
        if (actual != expected) begin
            $display("** Error at %0t ns: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    function automatic mp_pkg::sample_t random_sample();
        return mp_pkg::sample_t'(int'($urandom_range(4095)) - 2048);
    endfunction

    task automatic randomize_data();
        for (int i = 0; i < `MP_SIGNAL_SIZE; i++) begin
            y_model[i] = random_sample();
        end
        for (int a = 0; a < DICT_WORDS; a++) begin
            dict_model[a] = random_sample();
        end
    endtask

    // atoms 3 and 9 follow the sign pattern of y and atom 12 opposes it
    task automatic directed_data();
        for (int i = 0; i < `MP_SIGNAL_SIZE; i++) begin
            y_model[i] = mp_pkg::sample_t'((i % 2 == 0) ? 1800 : -1200);
        end
        for (int j = 0; j < `MP_DICT_SIZE; j++) begin
            for (int i = 0; i < `MP_SIGNAL_SIZE; i++) begin
                dict_model[j * `MP_SIGNAL_SIZE + i] =
                    mp_pkg::sample_t'(((j * 7 + i * 3) % 65) - 32);
            end
        end
        for (int i = 0; i < `MP_SIGNAL_SIZE; i++) begin
            dict_model[3 * `MP_SIGNAL_SIZE + i] = mp_pkg::sample_t'((i % 2 == 0) ? 2000 : -2000);
            dict_model[9 * `MP_SIGNAL_SIZE + i] = mp_pkg::sample_t'((i % 2 == 0) ? 2000 : -2000);
            dict_model[12 * `MP_SIGNAL_SIZE + i] = mp_pkg::sample_t'((i % 2 == 0) ? -1500 : 1500);
        end
    endtask

    task automatic load_memories();
        for (int i = 0; i < `MP_SIGNAL_SIZE; i++) begin
            @(posedge clock);
            load_write  <= 1'b1;
            load_target <= 1'b0;
            load_addr   <= mp_pkg::dict_addr_t'(i);
            load_data   <= y_model[i];
        end
        for (int a = 0; a < DICT_WORDS; a++) begin
            @(posedge clock);
            load_write  <= 1'b1;
            load_target <= 1'b1;
            load_addr   <= mp_pkg::dict_addr_t'(a);
            load_data   <= dict_model[a];
        end
        @(posedge clock);
        load_write <= 1'b0;
    endtask

    // extra start strobes land well inside the run, which lasts over 430 cycles
    task automatic run_engine(input bit extra_starts);
        int cycle;
        bit finished;
        cycle    = 0;
        finished = 1'b0;
        @(posedge clock);
        start <= 1'b1;
        while (!finished) begin
            @(posedge clock);
            cycle = cycle + 1;
            start <= extra_starts && (cycle % 45 == 0) && (cycle <= 360);
            @(negedge clock);
            finished = done;
        end
    endtask

    task automatic read_and_check();
        for (int k = 0; k < `MP_DICT_SIZE; k++) begin
            @(posedge clock);
            x_read_addr <= mp_pkg::atom_addr_t'(k);
            @(posedge clock);
            @(negedge clock);
            check_value(x_read_data, x_model[k], $sformatf("x[%0d]", k));
        end
    endtask

    task automatic load_run_check(input bit extra_starts, input int expected_runs);
        load_memories();
        predict_solution();
        run_engine(extra_starts);
        repeat (8) @(negedge clock);
        check_value(done_count, expected_runs, "done pulse count");
        read_and_check();
    endtask

    initial begin
        void'($urandom(71));
        clock       = 1'b0;
        reset_n     = 1'b0;
        load_write  = 1'b0;
        load_target = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        start       = 1'b0;
        x_read_addr = '0;

        repeat (2) @(posedge clock);
        reset_n <= 1'b1;

        // idle engine after reset
        repeat (10) begin
            @(negedge clock);
            check_value(done, 0, "done while idle");
        end

        randomize_data();
        load_run_check(1'b0, 1);

        // fresh data on each run exposes a stale x or residual
        for (int run = 0; run < 3; run++) begin
            randomize_data();
            load_run_check(1'b0, 2 + run);
        end

        randomize_data();
        load_run_check(1'b1, 5);

        directed_data();
        load_run_check(1'b0, 6);

        $display("All tests passed!");
        $finish;
    end

endmodule

/* source/mp_engine.sv */
`timescale 1ns/1ns
`include "mp_macros.svh"

module mp_engine (
    input  logic               clock,
    input  logic               reset_n,
    input  logic               load_write,
    input  logic               load_target,
    input  mp_pkg::dict_addr_t load_addr,
    input  mp_pkg::sample_t    load_data,
    input  logic               start,
    output logic               done,
    input  mp_pkg::atom_addr_t x_read_addr,
    output mp_pkg::coef_t      x_read_data
);

    logic                 y_write_enable;
    logic                 dict_write_enable;
    mp_pkg::signal_addr_t y_read_addr;
    mp_pkg::sample_t      y_read_data;
    mp_pkg::dict_addr_t   dict_addr;
    mp_pkg::sample_t      dict_data;

    logic                 clearing;
    mp_pkg::atom_addr_t   init_write_addr;
    mp_pkg::sample_t      init_write_data;
    logic                 loop_start;
    logic                 loop_done;

    logic                 proc_start;
    mp_pkg::dict_cmd_t    proc_cmd;
    mp_pkg::atom_addr_t   scale_atom;
    mp_pkg::sample_t      scale_value;
    logic                 proc_done;
    logic                 sweep_begin;
    logic                 product_valid;
    mp_pkg::atom_addr_t   product_atom;
    mp_pkg::sample_t      product_value;
    mp_pkg::atom_addr_t   max_atom;
    mp_pkg::sample_t      max_value;

    mp_pkg::signal_addr_t residual_read_addr;
    mp_pkg::sample_t      residual_read_data;
    logic                 proc_residual_write_enable;
    mp_pkg::signal_addr_t proc_residual_write_addr;
    mp_pkg::sample_t      proc_residual_write_data;
    logic                 residual_write_enable;
    mp_pkg::signal_addr_t residual_write_addr;
    mp_pkg::sample_t      residual_write_data;

    mp_pkg::atom_addr_t   loop_x_read_addr;
    mp_pkg::coef_t        loop_x_read_data;
    logic                 loop_x_write_enable;
    mp_pkg::atom_addr_t   loop_x_write_addr;
    mp_pkg::coef_t        loop_x_write_data;
    logic                 x_write_enable;
    mp_pkg::atom_addr_t   x_write_addr;
    mp_pkg::coef_t        x_write_data;

    // load decode, target 0 is y and 1 is the dictionary
    assign y_write_enable    = load_write && !load_target;
    assign dict_write_enable = load_write && load_target;

    // the fsm owns the residual and x write ports while clearing
    always_comb begin
        if (clearing) begin
            residual_write_enable = init_write_addr < mp_pkg::atom_addr_t'(`MP_SIGNAL_SIZE);
            residual_write_addr   = mp_pkg::signal_addr_t'(init_write_addr);
            residual_write_data   = init_write_data;
            x_write_enable        = 1'b1;
            x_write_addr          = init_write_addr;
            x_write_data          = '0;
        end else begin
            residual_write_enable = proc_residual_write_enable;
            residual_write_addr   = proc_residual_write_addr;
            residual_write_data   = proc_residual_write_data;
            x_write_enable        = loop_x_write_enable;
            x_write_addr          = loop_x_write_addr;
            x_write_data          = loop_x_write_data;
        end
    end

    mp_sync_ram #(.word_t(mp_pkg::sample_t), .DEPTH(`MP_SIGNAL_SIZE)) y_ram (
        .clock(clock), .write_enable(y_write_enable),
        .write_addr(mp_pkg::signal_addr_t'(load_addr)), .write_data(load_data),
        .read_addr_a(y_read_addr), .read_addr_b('0),
        .read_data_a(y_read_data), .read_data_b()
    );

    mp_sync_ram #(
        .word_t(mp_pkg::sample_t), .DEPTH(`MP_SIGNAL_SIZE * `MP_DICT_SIZE)
    ) dict_ram (
        .clock(clock), .write_enable(dict_write_enable),
        .write_addr(load_addr), .write_data(load_data),
        .read_addr_a(dict_addr), .read_addr_b('0),
        .read_data_a(dict_data), .read_data_b()
    );

    mp_sync_ram #(.word_t(mp_pkg::sample_t), .DEPTH(`MP_SIGNAL_SIZE)) residual_ram (
        .clock(clock), .write_enable(residual_write_enable),
        .write_addr(residual_write_addr), .write_data(residual_write_data),
        .read_addr_a(residual_read_addr), .read_addr_b('0),
        .read_data_a(residual_read_data), .read_data_b()
    );

    // port b serves host readback
    mp_sync_ram #(.word_t(mp_pkg::coef_t), .DEPTH(`MP_DICT_SIZE)) x_ram (
        .clock(clock), .write_enable(x_write_enable),
        .write_addr(x_write_addr), .write_data(x_write_data),
        .read_addr_a(loop_x_read_addr), .read_addr_b(x_read_addr),
        .read_data_a(loop_x_read_data), .read_data_b(x_read_data)
    );

    mp_alg_fsm alg_fsm_i (
        .clock(clock), .reset_n(reset_n), .start(start), .done(done),
        .loop_start(loop_start), .loop_done(loop_done),
        .y_read_addr(y_read_addr), .y_read_data(y_read_data),
        .clearing(clearing), .init_write_addr(init_write_addr),
        .init_write_data(init_write_data)
    );

    mp_main_loop main_loop_i (
        .clock(clock), .reset_n(reset_n),
        .loop_start(loop_start), .loop_done(loop_done),
        .proc_start(proc_start), .proc_cmd(proc_cmd),
        .scale_atom(scale_atom), .scale_value(scale_value), .proc_done(proc_done),
        .max_atom(max_atom), .max_value(max_value),
        .x_read_addr(loop_x_read_addr), .x_read_data(loop_x_read_data),
        .x_write_enable(loop_x_write_enable), .x_write_addr(loop_x_write_addr),
        .x_write_data(loop_x_write_data)
    );

    mp_dict_processor dict_processor_i (
        .clock(clock), .reset_n(reset_n),
        .proc_start(proc_start), .proc_cmd(proc_cmd),
        .scale_atom(scale_atom), .scale_value(scale_value),
        .dict_addr(dict_addr), .dict_data(dict_data),
        .residual_read_addr(residual_read_addr), .residual_read_data(residual_read_data),
        .residual_write_enable(proc_residual_write_enable),
        .residual_write_addr(proc_residual_write_addr),
        .residual_write_data(proc_residual_write_data),
        .sweep_begin(sweep_begin), .product_valid(product_valid),
        .product_atom(product_atom), .product_value(product_value),
        .proc_done(proc_done)
    );

    mp_max_identifier max_identifier_i (
        .clock(clock), .reset_n(reset_n), .sweep_begin(sweep_begin),
        .product_valid(product_valid), .product_atom(product_atom),
        .product_value(product_value), .max_atom(max_atom), .max_value(max_value)
    );

endmodule

/* source/mp_alg_fsm.sv */
`timescale 1ns/1ns
`include "mp_macros.svh"

module mp_alg_fsm (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 start,
    output logic                 done,
    output logic                 loop_start,
    input  logic                 loop_done,
    output mp_pkg::signal_addr_t y_read_addr,
    input  mp_pkg::sample_t      y_read_data,
    output logic                 clearing,
    output mp_pkg::atom_addr_t   init_write_addr,
    output mp_pkg::sample_t      init_write_data
);

    typedef enum logic [1:0] {
        IDLE,
        CLEAR,
        LAUNCH,
        WAIT_LOOP
    } state_t;

    state_t                                 state;
    logic [`MP_ATOM_ADDR_WIDTH:0]           index;
    logic [$clog2(`MP_SPARSITY+1)-1:0]      iteration;

    // y is read one cycle ahead of the write it feeds
    assign y_read_addr     = mp_pkg::signal_addr_t'(index);
    assign init_write_data = y_read_data;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state      <= IDLE;
            index      <= '0;
            iteration  <= '0;
            clearing   <= 1'b0;
            loop_start <= 1'b0;
            done       <= 1'b0;
        end else begin
            loop_start <= 1'b0;
            done       <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        index     <= '0;
                        iteration <= '0;
                        state     <= CLEAR;
                    end
                end
                // N+1 cycles, the first one only prefetches y[0]
                CLEAR: begin
                    if (index == `MP_DICT_SIZE) begin
                        clearing <= 1'b0;
                        state    <= LAUNCH;
                    end else begin
                        clearing <= 1'b1;
                        index    <= index + 1'b1;
                    end
                end
                LAUNCH: begin
                    loop_start <= 1'b1;
                    state      <= WAIT_LOOP;
                end
                WAIT_LOOP: begin
                    if (loop_done) begin
                        if (iteration == `MP_SPARSITY - 1) begin
                            done  <= 1'b1;
                            state <= IDLE;
                        end else begin
                            iteration <= iteration + 1'b1;
                            state     <= LAUNCH;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        init_write_addr <= mp_pkg::atom_addr_t'(index);
    end

endmodule

/* source/mp_main_loop.sv */
`timescale 1ns/1ns

module mp_main_loop (
    input  logic               clock,
    input  logic               reset_n,
    input  logic               loop_start,
    output logic               loop_done,
    output logic               proc_start,
    output mp_pkg::dict_cmd_t  proc_cmd,
    output mp_pkg::atom_addr_t scale_atom,
    output mp_pkg::sample_t    scale_value,
    input  logic               proc_done,
    input  mp_pkg::atom_addr_t max_atom,
    input  mp_pkg::sample_t    max_value,
    output mp_pkg::atom_addr_t x_read_addr,
    input  mp_pkg::coef_t      x_read_data,
    output logic               x_write_enable,
    output mp_pkg::atom_addr_t x_write_addr,
    output mp_pkg::coef_t      x_write_data
);

    typedef enum logic [2:0] {
        IDLE,
        SWEEP,
        X_READ,
        X_UPDATE,
        X_WRITE,
        SUBTRACT
    } state_t;

    state_t             state;
    mp_pkg::atom_addr_t win_atom;
    mp_pkg::sample_t    win_value;

    // the winner stays put for the x update and the subtraction
    assign x_read_addr = win_atom;
    assign scale_atom  = win_atom;
    assign scale_value = win_value;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state          <= IDLE;
            loop_done      <= 1'b0;
            proc_start     <= 1'b0;
            proc_cmd       <= mp_pkg::CMD_INNER_PRODUCTS;
            x_write_enable <= 1'b0;
        end else begin
            loop_done      <= 1'b0;
            proc_start     <= 1'b0;
            x_write_enable <= 1'b0;
            case (state)
                IDLE: begin
                    if (loop_start) begin
                        proc_start <= 1'b1;
                        proc_cmd   <= mp_pkg::CMD_INNER_PRODUCTS;
                        state      <= SWEEP;
                    end
                end
                SWEEP: begin
                    if (proc_done) begin
                        state <= X_READ;
                    end
                end
                // read-modify-write of x over three cycles
                X_READ: state <= X_UPDATE;
                X_UPDATE: begin
                    x_write_enable <= 1'b1;
                    state          <= X_WRITE;
                end
                X_WRITE: begin
                    proc_start <= 1'b1;
                    proc_cmd   <= mp_pkg::CMD_SUBTRACT_ATOM;
                    state      <= SUBTRACT;
                end
                SUBTRACT: begin
                    if (proc_done) begin
                        loop_done <= 1'b1;
                        state     <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == SWEEP && proc_done) begin
            win_atom  <= max_atom;
            win_value <= max_value;
        end
        if (state == X_UPDATE) begin
            x_write_addr <= win_atom;
            x_write_data <= x_read_data + mp_pkg::coef_t'(win_value);
        end
    end

endmodule

/* source/mp_max_identifier.sv */
`timescale 1ns/1ns
`include "mp_macros.svh"

module mp_max_identifier (
    input  logic               clock,
    input  logic               reset_n,
    input  logic               sweep_begin,
    input  logic               product_valid,
    input  mp_pkg::atom_addr_t product_atom,
    input  mp_pkg::sample_t    product_value,
    output mp_pkg::atom_addr_t max_atom,
    output mp_pkg::sample_t    max_value
);

    logic                              have_winner;
    logic signed [`MP_SAMPLE_WIDTH:0]  wide_value;
    logic        [`MP_SAMPLE_WIDTH:0]  new_mag;
    logic        [`MP_SAMPLE_WIDTH:0]  best_mag;
    logic                              take;

    // one extra bit so the most negative sample has a magnitude
    always_comb begin
        wide_value = {product_value[`MP_SAMPLE_WIDTH-1], product_value};
        new_mag    = wide_value[`MP_SAMPLE_WIDTH] ? -wide_value : wide_value;
        // strictly greater, so ties stay with the lower atom
        take       = product_valid && (!have_winner || new_mag > best_mag);
    end

    always_ff @(posedge clock) begin
        if (!reset_n || sweep_begin) begin
            have_winner <= 1'b0;
        end else if (take) begin
            have_winner <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            best_mag  <= new_mag;
            max_atom  <= product_atom;
            max_value <= product_value;
        end
    end

endmodule

/* source/mp_dict_processor.sv */
`timescale 1ns/1ns
`include "mp_macros.svh"

module mp_dict_processor (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 proc_start,
    input  mp_pkg::dict_cmd_t    proc_cmd,
    input  mp_pkg::atom_addr_t   scale_atom,
    input  mp_pkg::sample_t      scale_value,
    output mp_pkg::dict_addr_t   dict_addr,
    input  mp_pkg::sample_t      dict_data,
    output mp_pkg::signal_addr_t residual_read_addr,
    input  mp_pkg::sample_t      residual_read_data,
    output logic                 residual_write_enable,
    output mp_pkg::signal_addr_t residual_write_addr,
    output mp_pkg::sample_t      residual_write_data,
    output logic                 sweep_begin,
    output logic                 product_valid,
    output mp_pkg::atom_addr_t   product_atom,
    output mp_pkg::sample_t      product_value,
    output logic                 proc_done
);

    localparam mp_pkg::signal_addr_t LAST_SAMPLE =
        mp_pkg::signal_addr_t'(`MP_SIGNAL_SIZE - 1);
    localparam mp_pkg::atom_addr_t LAST_ATOM = mp_pkg::atom_addr_t'(`MP_DICT_SIZE - 1);

    mp_pkg::dict_cmd_t    cmd;
    logic                 issue_active;
    mp_pkg::atom_addr_t   issue_atom;
    mp_pkg::signal_addr_t issue_sample;
    logic                 rd_valid;
    mp_pkg::atom_addr_t   rd_atom;
    mp_pkg::signal_addr_t rd_sample;
    mp_pkg::acc_t         acc;
    mp_pkg::acc_t         mac_base;
    mp_pkg::acc_t         mac_sum;
    mp_pkg::acc_t         scaled;
    logic                 sweep_end;
    logic                 subtract_end;

    // issue stage addresses both memories in the same cycle
    assign residual_read_addr = issue_sample;
    assign dict_addr = mp_pkg::dict_addr_t'(issue_atom) * mp_pkg::dict_addr_t'(`MP_SIGNAL_SIZE)
                     + mp_pkg::dict_addr_t'(issue_sample);

    // data stage, one cycle behind the issue stage
    always_comb begin
        mac_base = (rd_sample == '0) ? mp_pkg::acc_t'(0) : acc;
        mac_sum  = mac_base + mp_pkg::acc_t'(residual_read_data) * mp_pkg::acc_t'(dict_data);
        scaled   = mp_pkg::acc_t'(scale_value) * mp_pkg::acc_t'(dict_data);
    end

    // the max identifier has taken the last product by the cycle after it
    assign sweep_end = product_valid && product_atom == LAST_ATOM
                    && cmd == mp_pkg::CMD_INNER_PRODUCTS;
    assign subtract_end = rd_valid && rd_sample == LAST_SAMPLE
                       && cmd == mp_pkg::CMD_SUBTRACT_ATOM;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            cmd                   <= mp_pkg::CMD_INNER_PRODUCTS;
            issue_active          <= 1'b0;
            issue_atom            <= '0;
            issue_sample          <= '0;
            rd_valid              <= 1'b0;
            sweep_begin           <= 1'b0;
            product_valid         <= 1'b0;
            residual_write_enable <= 1'b0;
            proc_done             <= 1'b0;
        end else begin
            sweep_begin <= proc_start && !issue_active
                        && proc_cmd == mp_pkg::CMD_INNER_PRODUCTS;
            rd_valid <= issue_active;
            product_valid <= rd_valid && rd_sample == LAST_SAMPLE
                          && cmd == mp_pkg::CMD_INNER_PRODUCTS;
            residual_write_enable <= rd_valid && cmd == mp_pkg::CMD_SUBTRACT_ATOM;
            proc_done <= sweep_end || subtract_end;

            if (proc_start && !issue_active) begin
                cmd          <= proc_cmd;
                issue_active <= 1'b1;
                issue_sample <= '0;
                // a subtraction touches only the winning atom
                issue_atom   <= (proc_cmd == mp_pkg::CMD_SUBTRACT_ATOM) ? scale_atom : '0;
            end else if (issue_active) begin
                if (issue_sample == LAST_SAMPLE) begin
                    issue_sample <= '0;
                    if (cmd == mp_pkg::CMD_SUBTRACT_ATOM || issue_atom == LAST_ATOM) begin
                        issue_active <= 1'b0;
                    end else begin
                        issue_atom <= issue_atom + 1'b1;
                    end
                end else begin
                    issue_sample <= issue_sample + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        rd_atom   <= issue_atom;
        rd_sample <= issue_sample;
        if (rd_valid) begin
            acc                 <= mac_sum;
            product_atom        <= rd_atom;
            product_value       <= mp_pkg::sample_t'(mac_sum >>> `MP_FRAC_BITS);
            residual_write_addr <= rd_sample;
            residual_write_data <= residual_read_data
                                 - mp_pkg::sample_t'(scaled >>> `MP_FRAC_BITS);
        end
    end

endmodule

/* source/mp_sync_ram.sv */
`timescale 1ns/1ns

module mp_sync_ram #(
    parameter type word_t = logic [15:0],
    parameter int DEPTH = 16
) (
    input  logic                     clock,
    input  logic                     write_enable,
    input  logic [$clog2(DEPTH)-1:0] write_addr,
    input  word_t                    write_data,
    input  logic [$clog2(DEPTH)-1:0] read_addr_a,
    input  logic [$clog2(DEPTH)-1:0] read_addr_b,
    output word_t                    read_data_a,
    output word_t                    read_data_b
);

    word_t mem [DEPTH];

    // registered reads, a read that collides with a write sees the old word
    always_ff @(posedge clock) begin
        if (write_enable) begin
            mem[write_addr] <= write_data;
        end
        read_data_a <= mem[read_addr_a];
        read_data_b <= mem[read_addr_b];
    end

endmodule

/* source/mp_pkg.sv */
`include "mp_macros.svh"

package mp_pkg;

    // y, residual, atoms and inner products
    typedef logic signed [`MP_SAMPLE_WIDTH-1:0] sample_t;

    // solution coefficients
    typedef logic signed [`MP_COEF_WIDTH-1:0] coef_t;

    // wide enough for a full sum of M products
    typedef logic signed [`MP_ACC_WIDTH-1:0] acc_t;

    typedef logic [`MP_SIGNAL_ADDR_WIDTH-1:0] signal_addr_t;
    typedef logic [`MP_ATOM_ADDR_WIDTH-1:0] atom_addr_t;
    typedef logic [`MP_DICT_ADDR_WIDTH-1:0] dict_addr_t;

    // commands understood by the dictionary processor
    typedef enum logic {
        CMD_INNER_PRODUCTS,
        CMD_SUBTRACT_ATOM
    } dict_cmd_t;

endpackage

/* source/mp_macros.svh */
`ifndef MP_MACROS_SVH
`define MP_MACROS_SVH

// geometry of one problem
`define MP_SIGNAL_SIZE 8
`define MP_DICT_SIZE 16
`define MP_SPARSITY 3

// fixed point formats
`define MP_FRAC_BITS 12
`define MP_SAMPLE_WIDTH 16
`define MP_COEF_WIDTH 32
`define MP_ACC_WIDTH 36

// address widths, dictionary is atom-major
`define MP_SIGNAL_ADDR_WIDTH 3
`define MP_ATOM_ADDR_WIDTH 4
`define MP_DICT_ADDR_WIDTH 7

`endif
